/* design/video_pkg.sv */
// **************************************************
// shared video types, coordinates are signed 16 bit
// line buffer address is 10 bits, so H_RES <= 1024
// **************************************************
package video_pkg;

    // screen coordinate, blanking runs negative, active starts at 0
    typedef logic signed [15:0] coord_t;

    // line buffer address, wide enough for 640 pixels
    typedef logic [9:0] lb_addr_t;

    // 12-bit colour
    typedef struct packed {
        logic [3:0] red;    // red channel
        logic [3:0] green;  // green channel
        logic [3:0] blue;   // blue channel
    } rgb_t;

    // test pattern select, latched once per frame
    typedef enum logic [1:0] {
        PAT_BARS     = 2'd0,  // 8 colour bars, 8 px wide
        PAT_CHECKER  = 2'd1,  // 8x8 black/white squares
        PAT_GRADIENT = 2'd2,  // red ramps on x, green on y
        PAT_XOR      = 2'd3   // grey from x xor y
    } pattern_t;

    // video out of the scanout stage, 15 bits
    typedef struct packed {
        logic hsync;  // polarity as configured
        logic vsync;  // polarity as configured
        logic de;     // active video
        rgb_t rgb;    // zero outside de
    } video_t;

    // line render request, 17 bits
    typedef struct packed {
        coord_t line;  // visible row to draw
        logic   bank;  // buffer bank to fill
    } line_req_t;

    // one pixel write into the line buffer, 24 bits
    typedef struct packed {
        logic     en;    // write strobe
        logic     bank;  // target bank
        lb_addr_t addr;  // pixel index in the line
        rgb_t     rgb;   // pixel colour
    } lb_wr_t;

endpackage

/* design/display_timing.sv */
// **************************************************
// outputs registered, sx/sy delayed to line up with them
// H_POL/V_POL 0 gives active low syncs
// **************************************************
module display_timing #(
    parameter int H_RES  = 640,   // active pixels
    parameter int V_RES  = 480,   // active lines
    parameter int H_FP   = 16,    // horizontal front porch
    parameter int H_SYNC = 96,    // horizontal sync width
    parameter int H_BP   = 48,    // horizontal back porch
    parameter int V_FP   = 10,    // vertical front porch
    parameter int V_SYNC = 2,     // vertical sync lines
    parameter int V_BP   = 33,    // vertical back porch
    parameter bit H_POL  = 1'b0,  // 1 for positive hsync
    parameter bit V_POL  = 1'b0   // 1 for positive vsync
) (
    input  logic              clk_pix,
    input  logic              rst,
    output logic              hsync,  // horizontal sync
    output logic              vsync,  // vertical sync
    output logic              de,     // data enable
    output logic              frame,  // first pixel of frame
    output logic              line,   // first blanking pixel of each line
    output video_pkg::coord_t sx,     // horizontal position
    output video_pkg::coord_t sy      // vertical position
);
    import video_pkg::*;

    // horizontal landmarks, blanking before 0
    localparam coord_t H_STA  = coord_t'(0 - H_FP - H_SYNC - H_BP);
    localparam coord_t HS_STA = coord_t'(0 - H_SYNC - H_BP);  // after front porch
    localparam coord_t HS_END = coord_t'(0 - H_BP);           // first back porch pixel
    localparam coord_t HA_END = coord_t'(H_RES - 1);

    // vertical landmarks
    localparam coord_t V_STA  = coord_t'(0 - V_FP - V_SYNC - V_BP);
    localparam coord_t VS_STA = coord_t'(0 - V_SYNC - V_BP);
    localparam coord_t VS_END = coord_t'(0 - V_BP);
    localparam coord_t VA_END = coord_t'(V_RES - 1);

    coord_t x;   // running column
    coord_t y;   // running row
    logic   hs_win;  // inside hsync window
    logic   vs_win;  // inside vsync window

    // sync runs from the end of the front porch up to the back porch
    assign hs_win = (x >= HS_STA) && (x < HS_END);
    assign vs_win = (y >= VS_STA) && (y < VS_END);

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            hsync <= ~H_POL;  // inactive level
            vsync <= ~V_POL;
            de    <= 1'b0;
            frame <= 1'b0;
            line  <= 1'b0;
        end else begin
            hsync <= hs_win ? H_POL : ~H_POL;
            vsync <= vs_win ? V_POL : ~V_POL;
            de    <= (y >= 0) && (x >= 0);  // both in active area
            frame <= (y == V_STA) && (x == H_STA);
            line  <= (x == H_STA);
        end
    end

    // position counter, wraps at last active pixel / line
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            x <= H_STA;
            y <= V_STA;
        end else if (x == HA_END) begin
            x <= H_STA;
            y <= (y == VA_END) ? V_STA : y + 16'sd1;
        end else begin
            x <= x + 16'sd1;
        end
    end

    // one cycle behind x/y, same stage as the syncs
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx <= H_STA;
            sy <= V_STA;
        end else begin
            sx <= x;
            sy <= y;
        end
    end

endmodule

/* design/pattern_gen.sv */
// **************************************************
// renders one line per request, H_RES+2 cycles
// pattern is latched only with the row 0 request
// **************************************************
module pattern_gen #(
    parameter int H_RES = 640  // pixels per line
) (
    input  logic                 clk_pix,
    input  logic                 rst,
    input  video_pkg::pattern_t  pattern,   // requested pattern
    input  logic                 req,       // line request, four-phase
    input  video_pkg::line_req_t line_req,  // row and bank, stable while req
    output logic                 ack,       // line written
    output video_pkg::lb_wr_t    wr         // pixel write to buffer
);
    import video_pkg::*;

    typedef enum logic [1:0] {
        IDLE = 2'd0,  // waiting for req
        DRAW = 2'd1,  // one pixel per cycle
        DONE = 2'd2   // ack held until req drops
    } state_t;

    localparam lb_addr_t H_LAST = lb_addr_t'(H_RES - 1);

    state_t   state;
    lb_addr_t px;       // pixel being drawn
    coord_t   row;      // latched row
    logic     bank;     // latched bank
    pattern_t cur_pat;  // pattern for this frame

    // colour rule, x and y are visible coordinates
    function automatic rgb_t pixel_colour(lb_addr_t x, coord_t y, pattern_t pat);
        rgb_t c;
        c = '0;
        case (pat)
            PAT_BARS: begin  // bar index is x[5:3]
                c.red   = {4{x[3]}};
                c.green = {4{x[4]}};
                c.blue  = {4{x[5]}};
            end
            PAT_CHECKER:  c = {12{x[3] ^ y[3]}};  // white or black
            PAT_GRADIENT: begin
                c.red   = x[3:0];
                c.green = y[3:0];
            end
            PAT_XOR: begin
                c.red   = x[3:0] ^ y[3:0];
                c.green = c.red;  // grey
                c.blue  = c.red;
            end
            default: c = '0;
        endcase
        return c;
    endfunction

    // control FSM
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state  <= IDLE;
            ack    <= 1'b0;
            wr.en  <= 1'b0;
        end else begin
            wr.en <= 1'b0;
            case (state)
                IDLE: if (req) state <= DRAW;  // accept
                DRAW: begin
                    wr.en <= 1'b1;
                    if (px == H_LAST) begin
                        state <= DONE;
                        ack   <= 1'b1;  // last write lands with ack
                    end
                end
                DONE: if (!req) begin
                    ack   <= 1'b0;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request latch and pixel datapath
    always_ff @(posedge clk_pix) begin
        if (state == IDLE && req) begin
            row  <= line_req.line;
            bank <= line_req.bank;
            px   <= '0;
            if (line_req.line == 16'sd0) cur_pat <= pattern;  // frame boundary
        end
        if (state == DRAW) begin
            wr.bank <= bank;
            wr.addr <= px;
            wr.rgb  <= pixel_colour(px, row, cur_pat);
            px      <= px + 10'd1;
        end
    end

    // buffer holds H_RES pixels per bank
    a_wr_addr: assert property (@(posedge clk_pix) disable iff (rst)
        wr.en |-> int'(wr.addr) < H_RES)
        else $error("pattern_gen: write address %0d out of line", wr.addr);

endmodule

/* design/line_buffer.sv */
// **************************************************
// two banks of one line, one write and one read port
// read data one cycle after address, no reset on data
// **************************************************
module line_buffer #(
    parameter int H_RES = 640  // pixels per bank
) (
    input  logic                clk_pix,
    input  video_pkg::lb_wr_t   wr,       // write from renderer
    input  logic                rd_bank,  // front bank
    input  video_pkg::lb_addr_t rd_addr,  // beam column
    output video_pkg::rgb_t     rd_rgb    // valid next cycle
);
    import video_pkg::*;

    localparam int AW = (H_RES > 1) ? $clog2(H_RES) : 1;  // index bits per bank

    rgb_t mem [0:1][0:H_RES-1];  // bank, pixel

    always_ff @(posedge clk_pix) begin
        if (wr.en) mem[wr.bank][wr.addr[AW-1:0]] <= wr.rgb;
    end

    // registered read so block RAM is inferred
    always_ff @(posedge clk_pix) begin
        rd_rgb <= mem[rd_bank][rd_addr[AW-1:0]];
    end

    // scanout addressing must stay inside one bank
    a_rd_addr: assert property (@(posedge clk_pix)
        !$isunknown(rd_addr) |-> int'(rd_addr) < H_RES)
        else $error("line_buffer: read address %0d beyond line", rd_addr);

endmodule

/* design/pixel_out.sv */
// **************************************************
// video out lags sx/sy and syncs by exactly 2 cycles
// a late ack leaves the stale bank on screen
// **************************************************
module pixel_out #(
    parameter int H_RES = 640,  // active pixels
    parameter int V_RES = 480   // active lines
) (
    input  logic                 clk_pix,
    input  logic                 rst,
    input  logic                 hsync,     // from timing
    input  logic                 vsync,
    input  logic                 de,
    input  logic                 line,      // start of line
    input  video_pkg::coord_t    sx,        // beam column
    input  video_pkg::coord_t    sy,        // beam row
    input  logic                 ack,       // render finished
    output logic                 req,       // render request
    output video_pkg::line_req_t line_req,  // row and back bank
    output logic                 rd_bank,   // front bank
    output video_pkg::lb_addr_t  rd_addr,   // read column
    input  video_pkg::rgb_t      rd_rgb,    // one cycle after rd_addr
    output video_pkg::video_t    video      // aligned output
);
    import video_pkg::*;

    coord_t next_row;  // row rendered during this line
    logic   next_vis;  // next row is on screen
    logic   front;     // bank being scanned
    logic   ready;     // back bank holds a finished line
    logic   hs_q;      // syncs, stage 1
    logic   vs_q;
    logic   de_q;

    assign next_row = sy + 16'sd1;
    assign next_vis = (next_row >= 16'sd0) && (next_row < coord_t'(V_RES));

    // handshake and bank bookkeeping
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            req   <= 1'b0;
            front <= 1'b0;
            ready <= 1'b0;
        end else begin
            if (req && ack) begin  // drop req, then renderer drops ack
                req   <= 1'b0;
                ready <= 1'b1;
            end
            if (line) begin
                if (ready) front <= ~front;  // swap in the new line
                ready <= 1'b0;
                if (next_vis) req <= 1'b1;
            end
        end
    end

    // request payload, back bank is the one not shown after the swap
    always_ff @(posedge clk_pix) begin
        if (line && next_vis) begin
            line_req.line <= next_row;
            line_req.bank <= ready ? front : ~front;
        end
    end

    assign rd_bank = front;
    assign rd_addr = de ? sx[9:0] : '0;  // park at 0 in blanking

    // stage 1 meets the RAM read, stage 2 is the output register
    always_ff @(posedge clk_pix) begin
        hs_q        <= hsync;
        vs_q        <= vsync;
        de_q        <= de;
        video.hsync <= hs_q;
        video.vsync <= vs_q;
        video.de    <= de_q;
        video.rgb   <= de_q ? rd_rgb : '0;  // black in blanking
        if (rst) begin
            de_q      <= 1'b0;
            video.de  <= 1'b0;
            video.rgb <= '0;
        end
    end

    // four-phase rule, no new req before the old ack has gone
    a_req_ack: assert property (@(posedge clk_pix) disable iff (rst)
        $rose(req) |-> !ack)
        else $error("pixel_out: req raised while ack still high");

    // render must finish inside one line period
    a_req_late: assert property (@(posedge clk_pix) disable iff (rst)
        line |-> !req)
        else $error("pixel_out: line %0d request still open", line_req.line);

    // timing active width agrees with the buffer width
    a_de_col: assert property (@(posedge clk_pix) disable iff (rst)
        de |-> (sx >= 16'sd0) && (sx < coord_t'(H_RES)))
        else $error("pixel_out: de at column %0d", sx);

endmodule

/* design/video_top.sv */
// **************************************************
// test-pattern subsystem, 640x480 defaults
// first frame after reset has no defined pattern
// **************************************************
module video_top #(
    parameter int H_RES  = 640,   // active pixels
    parameter int V_RES  = 480,   // active lines
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33,
    parameter bit H_POL  = 1'b0,  // negative hsync
    parameter bit V_POL  = 1'b0   // negative vsync
) (
    input  logic                clk_pix,
    input  logic                rst,
    input  video_pkg::pattern_t pattern,  // applied at next frame
    output video_pkg::video_t   video
);
    import video_pkg::*;

    logic      hsync;
    logic      vsync;
    logic      de;
    logic      line;
    coord_t    sx;
    coord_t    sy;
    logic      req;       // line handshake
    logic      ack;
    line_req_t line_req;
    lb_wr_t    wr;        // renderer to buffer
    logic      rd_bank;   // scanout read port
    lb_addr_t  rd_addr;
    rgb_t      rd_rgb;

    display_timing #(
        .H_RES (H_RES),  .V_RES (V_RES),
        .H_FP  (H_FP),   .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_FP  (V_FP),   .V_SYNC(V_SYNC), .V_BP(V_BP),
        .H_POL (H_POL),  .V_POL (V_POL)
    ) i_display_timing (
        .clk_pix(clk_pix), .rst(rst),
        .hsync(hsync), .vsync(vsync), .de(de),
        .frame(), .line(line), .sx(sx), .sy(sy)
    );

    pattern_gen #(.H_RES(H_RES)) i_pattern_gen (
        .clk_pix(clk_pix), .rst(rst), .pattern(pattern),
        .req(req), .line_req(line_req), .ack(ack), .wr(wr)
    );

    line_buffer #(.H_RES(H_RES)) i_line_buffer (
        .clk_pix(clk_pix), .wr(wr),
        .rd_bank(rd_bank), .rd_addr(rd_addr), .rd_rgb(rd_rgb)
    );

    pixel_out #(.H_RES(H_RES), .V_RES(V_RES)) i_pixel_out (
        .clk_pix(clk_pix), .rst(rst),
        .hsync(hsync), .vsync(vsync), .de(de), .line(line),
        .sx(sx), .sy(sy), .ack(ack), .req(req), .line_req(line_req),
        .rd_bank(rd_bank), .rd_addr(rd_addr), .rd_rgb(rd_rgb),
        .video(video)
    );

endmodule

/* testbench/clock_gen.sv */
// **************************************************
// clk_pix period 20, rst high for the first 2 edges
// **************************************************
module clock_gen #(
    parameter int HALF_PERIOD = 10,  // time units
    parameter int RST_CYCLES  = 2    // edges in reset
) (
    output logic clk_pix,
    output logic rst
);

    initial begin
        clk_pix = 1'b0;
        forever #HALF_PERIOD clk_pix = ~clk_pix;  // free running
    end

    initial begin
        rst <= 1'b1;
        repeat (RST_CYCLES) @(posedge clk_pix);
        rst <= 1'b0;  // released on a rising edge
    end

endmodule

/* testbench/video_tb.sv */
// **************************************************
// shrunken 64x16 display, both syncs active low
// frame 0 after reset is not checked, frames 1..5 are
// **************************************************
module video_tb;
    import video_pkg::*;

    localparam int H_RES      = 64;
    localparam int H_FP       = 4;
    localparam int H_SYNC     = 8;
    localparam int H_BP       = 4;
    localparam int V_RES      = 16;
    localparam int V_FP       = 1;
    localparam int V_SYNC     = 2;
    localparam int V_BP       = 2;
    localparam int LINE_CYC   = H_RES + H_FP + H_SYNC + H_BP;          // 80
    localparam int FRAME_CYC  = LINE_CYC * (V_RES + V_FP + V_SYNC + V_BP);  // 1680
    localparam int LAST_FRAME = 5;              // last checked frame
    localparam int TIMEOUT    = 7 * FRAME_CYC;  // 11760 cycles
    localparam int SETTLE     = 3;              // output pipe has unreset stages

    logic     clk_pix;
    logic     rst;
    pattern_t pattern;
    video_t   video;

    pattern_t pat_seq [0:LAST_FRAME+1];  // pattern each output frame should carry
    int       vs_starts;      // vsync starts seen at the output
    int       cyc;            // cycles since reset release
    int       px_x;           // column inside the de run
    int       px_y;           // de runs done in this frame
    int       vs_len;
    int       hs_len;
    int       vs_start_cyc;
    int       hs_start_cyc;
    bit       hs_seen;
    logic     prev_hs;
    logic     prev_vs;
    logic     prev_de;
    int       frame_errs;     // errors in the test now running
    int       total_errs;
    int       tests_run;
    int       tests_failed;
    int       pixels;         // pixels compared
    bit       done;

    clock_gen i_clock_gen (.clk_pix(clk_pix), .rst(rst));

    video_top #(
        .H_RES(H_RES), .V_RES(V_RES),
        .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
        .H_POL(1'b0), .V_POL(1'b0)
    ) i_video_top (
        .clk_pix(clk_pix), .rst(rst), .pattern(pattern), .video(video)
    );

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // colour rule for visible x, y
    function automatic rgb_t expected_rgb(input pattern_t pat, input int x, input int y);
        rgb_t c;
        int   bar;
        int   v;
        c   = '0;
        bar = (x / 8) % 8;
        v   = (x ^ y) % 16;
        case (pat)
            PAT_BARS: begin
                if (bar % 2 == 1) c.red = 4'hf;          // index bit 0
                if ((bar / 2) % 2 == 1) c.green = 4'hf;  // index bit 1
                if (bar / 4 == 1) c.blue = 4'hf;         // index bit 2
            end
            PAT_CHECKER: begin
                if ((((x / 8) ^ (y / 8)) % 2) == 1) c = 12'hfff;  // white square
            end
            PAT_GRADIENT: begin
                c.red   = 4'(x % 16);
                c.green = 4'(y % 16);
            end
            PAT_XOR: begin
                c.red   = 4'(v);
                c.green = 4'(v);
                c.blue  = 4'(v);
            end
            default: c = '0;
        endcase
        return c;
    endfunction

    function automatic bit in_test_frame();
        return (vs_starts - 1 >= 1) && (vs_starts - 1 <= LAST_FRAME);
    endfunction

    task automatic flag_error(input string msg);
        frame_errs = frame_errs + 1;
        total_errs = total_errs + 1;
        $display("FAILED t=%0t %s", $time, msg);
    endtask

    task automatic close_frame();
        if (px_y != V_RES)
            flag_error($sformatf("frame %0d had %0d de runs, expected %0d",
                                 vs_starts - 1, px_y, V_RES));
        tests_run = tests_run + 1;
        if (frame_errs != 0) tests_failed = tests_failed + 1;
        $display("test frame %0d %s: %s, %0d errors", vs_starts - 1,
                 pat_seq[vs_starts - 1].name(), (frame_errs == 0) ? "passed" : "failed",
                 frame_errs);
    endtask

    // compare process, samples the output on the falling edge
    always @(negedge clk_pix) begin : compare
        logic hs_a;
        logic vs_a;
        logic de_a;
        rgb_t want;
        hs_a = (video.hsync === 1'b0);  // active low, X reads inactive
        vs_a = (video.vsync === 1'b0);
        de_a = (video.de === 1'b1);
        if (rst) begin
            cyc       = 0;
            vs_starts = 0;
            px_x      = 0;
            px_y      = 0;
            hs_seen   = 1'b0;
            done      = 1'b0;
        end else begin
            cyc = cyc + 1;
            if (cyc == SETTLE) begin  // reset state of the output
                frame_errs = 0;
                if (video.hsync !== 1'b1 || video.vsync !== 1'b1)
                    flag_error($sformatf("syncs %b/%b not inactive after reset",
                                         video.hsync, video.vsync));
                if (video.de !== 1'b0 || video.rgb !== 12'h000)
                    flag_error($sformatf("de %b rgb %h after reset", video.de, video.rgb));
                tests_run = tests_run + 1;
                if (frame_errs != 0) tests_failed = tests_failed + 1;
                $display("test reset: %s", (frame_errs == 0) ? "passed" : "failed");
            end
            if (cyc > SETTLE) begin
                if (vs_a && !prev_vs) begin  // frame boundary
                    if (in_test_frame()) close_frame();
                    vs_starts  = vs_starts + 1;
                    frame_errs = 0;
                    px_x       = 0;
                    px_y       = 0;
                    vs_len     = 0;
                    if (in_test_frame() && cyc - vs_start_cyc != FRAME_CYC)
                        flag_error($sformatf("frame period %0d, expected %0d",
                                             cyc - vs_start_cyc, FRAME_CYC));
                    vs_start_cyc = cyc;
                    if (vs_starts - 1 > LAST_FRAME) done = 1'b1;
                end
                if (vs_a) vs_len = vs_len + 1;
                if (!vs_a && prev_vs && in_test_frame() && vs_len != V_SYNC * LINE_CYC)
                    flag_error($sformatf("vsync %0d cycles, expected %0d",
                                         vs_len, V_SYNC * LINE_CYC));
                if (hs_a && !prev_hs) begin  // line period from hsync to hsync
                    if (hs_seen && in_test_frame() && cyc - hs_start_cyc != LINE_CYC)
                        flag_error($sformatf("line period %0d, expected %0d",
                                             cyc - hs_start_cyc, LINE_CYC));
                    hs_seen      = 1'b1;
                    hs_start_cyc = cyc;
                    hs_len       = 0;
                end
                if (hs_a) hs_len = hs_len + 1;
                if (!hs_a && prev_hs && in_test_frame() && hs_len != H_SYNC)
                    flag_error($sformatf("hsync %0d cycles, expected %0d", hs_len, H_SYNC));
                if (de_a) begin
                    if (in_test_frame()) begin
                        want   = expected_rgb(pat_seq[vs_starts - 1], px_x, px_y);
                        pixels = pixels + 1;
                        if (video.rgb !== want)
                            flag_error($sformatf("pixel x=%0d y=%0d expected %h seen %h",
                                                 px_x, px_y, want, video.rgb));
                    end
                    px_x = px_x + 1;
                end else if (in_test_frame() && video.rgb !== 12'h000) begin
                    flag_error($sformatf("rgb %h while de low", video.rgb));
                end
                if (!de_a && prev_de) begin  // end of a de run
                    if (in_test_frame() && px_x != H_RES)
                        flag_error($sformatf("de run of %0d cycles at y=%0d, expected %0d",
                                             px_x, px_y, H_RES));
                    px_y = px_y + 1;
                    px_x = 0;
                end
            end
            prev_hs = hs_a;
            prev_vs = vs_a;
            prev_de = de_a;
        end
    end

    // stimulus, pattern for frame k set just after its vsync starts
    initial begin : stimulus
        logic [31:0] lfsr;
        logic [1:0]  pick;
        bit          ok;
        pattern <= PAT_BARS;
        lfsr = 32'hffda_b754;
        for (int i = 0; i < 2; i++) begin
            pick[i] = lfsr[0];  // one bit per step
            lfsr    = lfsr_next(lfsr);
        end
        pat_seq[0] = PAT_XOR;  // frame 0 not checked
        pat_seq[1] = PAT_BARS;
        pat_seq[2] = PAT_CHECKER;
        pat_seq[3] = PAT_GRADIENT;
        pat_seq[4] = PAT_XOR;
        pat_seq[5] = pattern_t'(pick);
        pat_seq[6] = pattern_t'(pick ^ 2'b01);  // only ever applied mid-frame 5
        for (int k = 0; k <= LAST_FRAME; k++) begin
            while (vs_starts < k + 1) @(posedge clk_pix);
            repeat (3) @(posedge clk_pix);
            pattern <= pat_seq[k];  // ahead of the row 0 request
            while (vs_starts != k + 1 || px_y < V_RES / 2) @(posedge clk_pix);
            pattern <= pat_seq[k + 1];  // mid-frame, must not touch frame k
        end
        while (!done) @(posedge clk_pix);
        $display("tests run %0d, passed %0d, failed %0d, pixels %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, pixels, total_errs);
        ok = (tests_failed == 0) && (total_errs == 0);
        if (tests_run != LAST_FRAME + 1) begin
            $display("ERROR: only %0d of %0d tests finished", tests_run, LAST_FRAME + 1);
            ok = 1'b0;
        end
        if (ok)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // hang guard, a little over the 6 frames the run needs
    initial begin : watchdog
        int wd_cyc;
        wd_cyc = 0;
        while (wd_cyc < TIMEOUT) begin
            @(posedge clk_pix);
            wd_cyc = wd_cyc + 1;
        end
        $display("ERROR: timeout after %0d cycles, the run stalled in frame %0d",
                 TIMEOUT, vs_starts - 1);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* build.f */
design/video_pkg.sv
design/display_timing.sv
design/pattern_gen.sv
design/line_buffer.sv
design/pixel_out.sv
design/video_top.sv
testbench/clock_gen.sv
testbench/video_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, then judge the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    -f build.f --top-module video_tb --Mdir obj_dir -o video_sim

./obj_dir/video_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "PASS: all tests" "$LOG"; then
    echo "simulation stopped without a result"
    exit 1
fi
echo "simulation passed"
